//--- lsu_top.f
source/lsu_pkg.sv
source/lsu_request_decode.sv
source/store_buffer.sv
source/data_ram.sv
source/load_align.sv
source/lsu_top.sv
testbench/lsu_chk.sv
testbench/lsu_tb.sv

//--- Bender.yml
package:
  name: lsu

dependencies: {}

sources:
  - source/lsu_pkg.sv
  - source/lsu_request_decode.sv
  - source/store_buffer.sv
  - source/data_ram.sv
  - source/load_align.sv
  - source/lsu_top.sv
  - target: test
    files:
      - testbench/lsu_chk.sv
      - testbench/lsu_tb.sv

//--- testbench/lsu_tb.sv
`default_nettype none
`timescale 1ns/10ps

// Testbench for the memory stage; it plays the core and the ROB
module lsu_tb;

    localparam int n_words  = 16;     // Small window, so loads often hit buffered stores
    localparam int n_random = 800;

    logic                           clk;
    logic                           rst_n;
    logic [lsu_pkg::xlen-1:0]       addr;
    logic [lsu_pkg::xlen-1:0]       wdata;
    logic [2:0]                     funct3;
    logic [lsu_pkg::rob_idx_w-1:0]  rob_idx;
    logic                           store_req;
    logic                           load_req;
    logic                           complete;
    logic [lsu_pkg::rob_idx_w-1:0]  complete_idx;
    logic                           exception;
    logic                           stall;
    logic                           load_valid;
    logic [lsu_pkg::xlen-1:0]       load_data;

    // Architectural bytes, and stores the ROB has not completed yet (oldest first)
    logic [7:0]                     arch_mem [4*n_words];
    logic [31:0]                    sq_addr [$];
    logic [2:0]                     sq_f3 [$];
    logic [31:0]                    sq_data [$];
    logic [lsu_pkg::rob_idx_w-1:0]  sq_rob [$];
    logic [lsu_pkg::rob_idx_w-1:0]  next_rob;
    bit                             fresh_store;     // Newest store still in decode, no entry yet
    logic                           exp_valid [2];   // Index 1 is due at this negedge
    logic [31:0]                    exp_data [2];

    lsu_top lsu_top_i (
        .clk, .rst_n, .addr, .wdata, .funct3, .rob_idx, .store_req, .load_req,
        .complete, .complete_idx, .exception, .stall, .load_valid, .load_data
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected)
            stop_run($sformatf("[FAIL] %0d ns: %s, got %h, expected %h",
                               $time, what, actual, expected));
    endtask

    function automatic int size_of(input logic [2:0] f3);
        return 1 << f3[1:0];                 // 1, 2 or 4 bytes
    endfunction

    function automatic bit is_aligned(input logic [31:0] a, input logic [2:0] f3);
        return (a % size_of(f3)) == 0;
    endfunction

    // Byte as a load sees it: memory with the pending stores laid over in order
    function automatic logic [7:0] view_byte(input int a);
        logic [7:0] b;
        int         sa;
        b = arch_mem[a];
        for (int i = 0; i < sq_addr.size(); i++) begin
            sa = sq_addr[i];
            if (a >= sa && a < sa + size_of(sq_f3[i]))
                b = sq_data[i][8*(a-sa) +: 8];   // Later stores win
        end
        return b;
    endfunction

    function automatic logic [31:0] expected_load(input logic [31:0] a, input logic [2:0] f3);
        logic [31:0] raw;
        raw = '0;
        for (int i = 0; i < size_of(f3); i++)
            raw[8*i +: 8] = view_byte(a + i);   // Little endian
        case (f3)
            lsu_pkg::f3_lb: return {{24{raw[7]}}, raw[7:0]};
            lsu_pkg::f3_lh: return {{16{raw[15]}}, raw[15:0]};
            default:        return raw;          // Unsigned forms are zero above the size
        endcase
    endfunction

    function automatic logic [31:0] rand_addr(input logic [2:0] f3, input bit may_misalign);
        logic [31:0] a;
        a = 32'($urandom_range(4*n_words - 1));
        if (!may_misalign || $urandom_range(3) != 0)
            a[1:0] = a[1:0] & ~2'(size_of(f3) - 1);   // Most requests aligned
        return a;
    endfunction

    function automatic logic [2:0] pick_load_f3();
        case ($urandom_range(4))
            0:       return lsu_pkg::f3_lb;
            1:       return lsu_pkg::f3_lh;
            2:       return lsu_pkg::f3_lw;
            3:       return lsu_pkg::f3_lbu;
            default: return lsu_pkg::f3_lhu;
        endcase
    endfunction

    // One clock: update the ROB model, drive at posedge, check and record at negedge
    task automatic run_cycle(input bit st, input bit ld, input logic [31:0] a,
                             input logic [31:0] d, input logic [2:0] f3,
                             input bit cmp, input bit exc);
        logic [lsu_pkg::rob_idx_w-1:0] cidx;
        bit                            do_cmp;
        cidx   = '0;
        do_cmp = cmp && sq_addr.size() > int'(fresh_store);   // Only stores with an entry
        if (do_cmp) begin
            cidx = sq_rob[0];                    // In order, oldest first
            for (int i = 0; i < size_of(sq_f3[0]); i++)
                arch_mem[sq_addr[0] + i] = sq_data[0][8*i +: 8];
            void'(sq_addr.pop_front());
            void'(sq_f3.pop_front());
            void'(sq_data.pop_front());
            void'(sq_rob.pop_front());
        end
        if (exc) begin
            sq_addr.delete();                    // Speculative stores are gone
            sq_f3.delete();
            sq_data.delete();
            sq_rob.delete();
        end
        @(posedge clk);
        store_req    <= st;
        load_req     <= ld;
        addr         <= a;
        wdata        <= d;
        funct3       <= f3;
        rob_idx      <= next_rob;
        complete     <= do_cmp;
        complete_idx <= cidx;
        exception    <= exc;
        @(negedge clk);
        check_equal(load_valid, exp_valid[1], "load_valid");
        if (exp_valid[1])
            check_equal(load_data, exp_data[1], "load_data");
        exp_valid[1] = exp_valid[0];
        exp_data[1]  = exp_data[0];
        exp_valid[0] = ld && is_aligned(a, f3);   // Misaligned load returns nothing
        exp_data[0]  = exp_valid[0] ? expected_load(a, f3) : '0;
        // Stall seen now is what decode samples at the next edge
        fresh_store = 1'b0;
        if (st && !stall && is_aligned(a, f3)) begin
            sq_addr.push_back(a);
            sq_f3.push_back(f3);
            sq_data.push_back(d);
            sq_rob.push_back(next_rob);
            next_rob    = next_rob + 1'b1;
            fresh_store = 1'b1;
        end
        if (lsu_top_i.store_buffer_i.lsu_chk_i.fail_count != 0)
            stop_run("A store buffer assertion failed");
    endtask

    task automatic raise_exception();
        repeat (2) run_cycle(1'b0, 1'b0, '0, '0, '0, 1'($urandom_range(1)), 1'b0);
        run_cycle(1'b0, 1'b0, '0, '0, '0, 1'($urandom_range(1)), 1'b1);
    endtask

    // Complete everything, then wait out a quiet period longer than the buffer depth
    task automatic drain_buffer();
        int quiet;
        int guard;
        quiet = 0;
        guard = 0;
        while (quiet <= lsu_pkg::sb_depth) begin
            run_cycle(1'b0, 1'b0, '0, '0, '0, 1'b1, 1'b0);
            quiet = (!stall && sq_addr.size() == 0) ? quiet + 1 : 0;
            guard++;
            if (guard > 64)
                stop_run("Timeout while waiting for the store buffer to drain");
        end
    endtask

    task automatic random_cycle();
        int         op;
        bit         cmp;
        logic [2:0] f3;
        op  = $urandom_range(99);
        cmp = $urandom_range(99) < 35;
        if (op < 3) begin
            raise_exception();
        end else if (op < 43 && !stall) begin
            f3 = 3'($urandom_range(2));          // sb, sh or sw
            run_cycle(1'b1, 1'b0, rand_addr(f3, 1'b1), $urandom, f3, cmp, 1'b0);
        end else if (op < 83) begin
            f3 = pick_load_f3();
            run_cycle(1'b0, 1'b1, rand_addr(f3, 1'b1), '0, f3, cmp, 1'b0);
        end else begin
            run_cycle(1'b0, 1'b0, '0, '0, '0, cmp, 1'b0);
        end
    endtask

    initial begin
        int         guard;
        logic [2:0] f3;
        void'($urandom(32'hcd9d));
        rst_n = 1'b0;
        addr = '0;
        wdata = '0;
        funct3 = '0;
        rob_idx = '0;
        store_req = 1'b0;
        load_req = 1'b0;
        complete = 1'b0;
        complete_idx = '0;
        exception = 1'b0;
        next_rob = '0;
        fresh_store = 1'b0;
        exp_valid = '{1'b0, 1'b0};
        exp_data  = '{32'h0, 32'h0};
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        for (int w = 0; w < n_words; w++) begin   // RAM powers up undefined
            run_cycle(1'b1, 1'b0, 32'(4*w), $urandom, lsu_pkg::f3_sw, 1'b0, 1'b0);
            run_cycle(1'b0, 1'b0, '0, '0, '0, 1'b1, 1'b0);
        end
        drain_buffer();
        // Overlapping stores to one word, then loads before any completes
        run_cycle(1'b1, 1'b0, 32'd20, 32'h11223344, lsu_pkg::f3_sw, 1'b0, 1'b0);
        run_cycle(1'b1, 1'b0, 32'd21, 32'h000000aa, lsu_pkg::f3_sb, 1'b0, 1'b0);
        run_cycle(1'b1, 1'b0, 32'd22, 32'h0000bbcc, lsu_pkg::f3_sh, 1'b0, 1'b0);
        run_cycle(1'b0, 1'b1, 32'd20, '0, lsu_pkg::f3_lw, 1'b0, 1'b0);
        run_cycle(1'b0, 1'b1, 32'd23, '0, lsu_pkg::f3_lb, 1'b0, 1'b0);
        drain_buffer();
        guard = 0;
        while (!stall) begin                     // Fill without completing
            run_cycle(1'b1, 1'b0, rand_addr(lsu_pkg::f3_sw, 1'b0), $urandom,
                      lsu_pkg::f3_sw, 1'b0, 1'b0);
            guard++;
            if (guard > 20)
                stop_run("Timeout while waiting for stall to rise");
        end
        // Stall must come exactly when every entry is taken
        check_equal(sq_addr.size(), lsu_pkg::sb_depth, "stores held when stall rose");
        repeat (6) begin
            f3 = pick_load_f3();
            run_cycle(1'b0, 1'b1, rand_addr(f3, 1'b0), '0, f3, 1'b0, 1'b0);
            check_equal(stall, 1'b1, "stall with a full buffer");
        end
        drain_buffer();
        repeat (n_random) random_cycle();
        drain_buffer();
        for (int w = 0; w < n_words; w++)        // RAM must hold the completed stores
            run_cycle(1'b0, 1'b1, 32'(4*w), '0, lsu_pkg::f3_lw, 1'b0, 1'b0);
        repeat (4) run_cycle(1'b0, 1'b0, '0, '0, '0, 1'b0, 1'b0);
        if (lsu_top_i.store_buffer_i.lsu_chk_i.fail_count == 0) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            stop_run("A store buffer assertion failed");
        end
    end

endmodule

`default_nettype wire

//--- testbench/lsu_chk.sv
`default_nettype none
`timescale 1ns/10ps

// Store buffer checks, bound into the store buffer
module lsu_chk (
    input wire                           clk,
    input wire                           rst_n,
    input wire                           exception,
    input wire                           dec_store,
    input wire                           mem_we,
    input wire [lsu_pkg::sb_depth-1:0]   valid,
    input wire [lsu_pkg::sb_depth-1:0]   committed,
    input wire [lsu_pkg::sb_ptr_w-1:0]   tail,
    input wire [lsu_pkg::sb_ptr_w:0]     count
);

    int unsigned fail_count = 0;

    // A RAM write needs an entry to come from
    drain_needs_entry: assert property (@(posedge clk) disable iff (!rst_n)
        mem_we |-> (count != '0))
        else begin $error("mem_we with an empty store buffer"); fail_count++; end

    // Stall keeps a free slot for every store leaving decode
    store_finds_slot: assert property (@(posedge clk) disable iff (!rst_n)
        dec_store |-> !valid[tail])
        else begin $error("Store accepted with no free entry"); fail_count++; end

    flush_clears_speculative: assert property (@(posedge clk) disable iff (!rst_n)
        exception |=> ((valid & ~committed) == '0))
        else begin $error("Uncommitted entry left after exception"); fail_count++; end

endmodule

bind store_buffer lsu_chk lsu_chk_i (
    .clk(clk), .rst_n(rst_n), .exception(exception), .dec_store(dec_store),
    .mem_we(mem_we), .valid(valid), .committed(committed), .tail(tail), .count(count)
);

`default_nettype wire

//--- source/lsu_top.sv
`default_nettype none
`timescale 1ns/10ps

// Memory stage: request decode, store buffer, data RAM and load alignment
module lsu_top (
    input  wire                               clk,
    input  wire                               rst_n,
    input  wire  [lsu_pkg::xlen-1:0]          addr,
    input  wire  [lsu_pkg::xlen-1:0]          wdata,
    input  wire  [2:0]                        funct3,
    input  wire  [lsu_pkg::rob_idx_w-1:0]     rob_idx,
    input  wire                               store_req,
    input  wire                               load_req,
    input  wire                               complete,
    input  wire  [lsu_pkg::rob_idx_w-1:0]     complete_idx,
    input  wire                               exception,
    output logic                              stall,
    output logic                              load_valid,
    output logic [lsu_pkg::xlen-1:0]          load_data
);

    // Decode stage outputs
    logic                           dec_store;
    logic                           dec_load;
    logic [lsu_pkg::ram_addr_w-1:0] dec_word;
    logic [1:0]                     dec_byte_off;
    logic [lsu_pkg::mask_w-1:0]     dec_mask;
    logic [lsu_pkg::xlen-1:0]       dec_wdata;
    logic [2:0]                     dec_funct3;
    logic [lsu_pkg::rob_idx_w-1:0]  dec_rob_idx;

    // Drain port into the RAM
    logic                           mem_we;
    logic [lsu_pkg::ram_addr_w-1:0] mem_word;
    logic [lsu_pkg::mask_w-1:0]     mem_mask;
    logic [lsu_pkg::xlen-1:0]       mem_wdata;

    // Load return path
    logic [lsu_pkg::mask_w-1:0]     fwd_mask;
    logic [lsu_pkg::xlen-1:0]       fwd_data;
    logic [lsu_pkg::xlen-1:0]       rd_data;

    lsu_request_decode lsu_request_decode_i (
        .clk, .rst_n, .addr, .wdata, .funct3, .rob_idx, .store_req, .load_req, .stall,
        .dec_store, .dec_load, .dec_word, .dec_byte_off, .dec_mask, .dec_wdata,
        .dec_funct3, .dec_rob_idx
    );

    store_buffer store_buffer_i (
        .clk, .rst_n, .dec_store, .dec_load, .dec_word, .dec_mask, .dec_wdata,
        .dec_rob_idx, .complete, .complete_idx, .exception, .stall,
        .mem_we, .mem_word, .mem_mask, .mem_wdata, .fwd_mask, .fwd_data
    );

    data_ram data_ram_i (
        .clk,
        .we    (mem_we),
        .waddr (mem_word),
        .wmask (mem_mask),
        .wdata (mem_wdata),
        .re    (dec_load),     // Read in step with the forwarding lookup
        .raddr (dec_word),
        .rdata (rd_data)
    );

    load_align load_align_i (
        .clk, .rst_n, .dec_load, .dec_byte_off, .dec_funct3, .fwd_mask, .fwd_data,
        .rd_data, .load_valid, .load_data
    );

endmodule

`default_nettype wire

//--- source/load_align.sv
`default_nettype none
`timescale 1ns/10ps

// Load result path: merge forwarded bytes over RAM data, align and extend
module load_align (
    input  wire                               clk,
    input  wire                               rst_n,
    input  wire                               dec_load,
    input  wire  [1:0]                        dec_byte_off,
    input  wire  [2:0]                        dec_funct3,
    input  wire  [lsu_pkg::mask_w-1:0]        fwd_mask,
    input  wire  [lsu_pkg::xlen-1:0]          fwd_data,
    input  wire  [lsu_pkg::xlen-1:0]          rd_data,
    output logic                              load_valid,
    output logic [lsu_pkg::xlen-1:0]          load_data
);

    logic                       valid_q;
    logic [1:0]                 off_q;
    logic [2:0]                 f3_q;
    logic [lsu_pkg::xlen-1:0]   merged;
    logic [lsu_pkg::xlen-1:0]   shifted;

    // One stage to line up with the RAM read register
    always_ff @(posedge clk) begin
        if (!rst_n)
            valid_q <= 1'b0;
        else
            valid_q <= dec_load;
    end

    always_ff @(posedge clk) begin
        off_q <= dec_byte_off;
        f3_q  <= dec_funct3;
    end

    always_comb begin
        // Buffered store bytes win over RAM
        for (int b = 0; b < lsu_pkg::mask_w; b++) begin
            merged[8*b +: 8] = fwd_mask[b] ? fwd_data[8*b +: 8] : rd_data[8*b +: 8];
        end
        shifted = merged >> {off_q, 3'b000};   // Addressed lane down to bit 0
        case (f3_q)
            lsu_pkg::f3_lb:  load_data = {{24{shifted[7]}}, shifted[7:0]};
            lsu_pkg::f3_lh:  load_data = {{16{shifted[15]}}, shifted[15:0]};
            lsu_pkg::f3_lbu: load_data = {24'b0, shifted[7:0]};
            lsu_pkg::f3_lhu: load_data = {16'b0, shifted[15:0]};
            default:         load_data = shifted;   // lw, offset is zero
        endcase
    end

    assign load_valid = valid_q;

endmodule

`default_nettype wire

//--- source/data_ram.sv
`default_nettype none
`timescale 1ns/10ps

// Word RAM, byte-enabled write port and one registered read port
module data_ram (
    input  wire                               clk,
    input  wire                               we,
    input  wire  [lsu_pkg::ram_addr_w-1:0]    waddr,
    input  wire  [lsu_pkg::mask_w-1:0]        wmask,
    input  wire  [lsu_pkg::xlen-1:0]          wdata,
    input  wire                               re,
    input  wire  [lsu_pkg::ram_addr_w-1:0]    raddr,
    output logic [lsu_pkg::xlen-1:0]          rdata
);

    logic [lsu_pkg::xlen-1:0] mem [lsu_pkg::ram_words];

    // Read port
    // Same-address collision returns the word before this edge's write
    always_ff @(posedge clk) begin
        if (re) begin
            rdata <= mem[raddr];
        end
    end

    // Write port, one lane per strobe bit
    always_ff @(posedge clk) begin
        if (we) begin
            for (int b = 0; b < lsu_pkg::mask_w; b++) begin
                if (wmask[b]) begin
                    mem[waddr][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- source/store_buffer.sv
`default_nettype none
`timescale 1ns/10ps

// Circular queue of pending stores with commit marks and byte forwarding
module store_buffer (
    input  wire                               clk,
    input  wire                               rst_n,
    input  wire                               dec_store,
    input  wire                               dec_load,
    input  wire  [lsu_pkg::ram_addr_w-1:0]    dec_word,
    input  wire  [lsu_pkg::mask_w-1:0]        dec_mask,
    input  wire  [lsu_pkg::xlen-1:0]          dec_wdata,
    input  wire  [lsu_pkg::rob_idx_w-1:0]     dec_rob_idx,
    input  wire                               complete,
    input  wire  [lsu_pkg::rob_idx_w-1:0]     complete_idx,
    input  wire                               exception,
    output logic                              stall,
    output logic                              mem_we,
    output logic [lsu_pkg::ram_addr_w-1:0]    mem_word,
    output logic [lsu_pkg::mask_w-1:0]        mem_mask,
    output logic [lsu_pkg::xlen-1:0]          mem_wdata,
    output logic [lsu_pkg::mask_w-1:0]        fwd_mask,
    output logic [lsu_pkg::xlen-1:0]          fwd_data
);

    // Entry state
    logic [lsu_pkg::sb_depth-1:0]   valid;
    logic [lsu_pkg::sb_depth-1:0]   committed;
    logic [lsu_pkg::ram_addr_w-1:0] ent_word [lsu_pkg::sb_depth];
    logic [lsu_pkg::mask_w-1:0]     ent_mask [lsu_pkg::sb_depth];
    logic [lsu_pkg::xlen-1:0]       ent_data [lsu_pkg::sb_depth];
    logic [lsu_pkg::rob_idx_w-1:0]  ent_rob  [lsu_pkg::sb_depth];

    logic [lsu_pkg::sb_ptr_w-1:0]   head;          // Oldest entry
    logic [lsu_pkg::sb_ptr_w-1:0]   tail;          // Next free slot
    logic [lsu_pkg::sb_ptr_w:0]     count;         // One extra bit to tell full from empty
    logic [lsu_pkg::sb_ptr_w:0]     count_next;
    logic [lsu_pkg::sb_ptr_w:0]     n_keep;

    logic [lsu_pkg::sb_depth-1:0]   done_hit;      // Entry being completed this cycle
    logic [lsu_pkg::sb_depth-1:0]   keep;          // Entry survives an exception
    logic                           drain;

    logic [lsu_pkg::sb_ptr_w-1:0]   fwd_idx;
    logic [lsu_pkg::mask_w-1:0]     fwd_mask_c;
    logic [lsu_pkg::xlen-1:0]       fwd_data_c;

    // A completion in the same cycle as an exception still counts
    always_comb begin
        for (int i = 0; i < lsu_pkg::sb_depth; i++) begin
            done_hit[i] = complete & valid[i] & ~committed[i]
                        & (ent_rob[i] == complete_idx);
        end
        keep = valid & (committed | done_hit);
    end

    // Kept entries are a prefix from head, so their number gives the new tail
    always_comb begin
        n_keep = '0;
        for (int i = 0; i < lsu_pkg::sb_depth; i++) begin
            n_keep = n_keep + keep[i];
        end
    end

    // Oldest entry goes to RAM as soon as it is committed
    assign drain     = valid[head] & committed[head];
    assign mem_we    = drain;
    assign mem_word  = ent_word[head];
    assign mem_mask  = ent_mask[head];
    assign mem_wdata = ent_data[head];

    // Count the store still in decode so it always finds a free slot
    assign stall = (count + dec_store) >= lsu_pkg::sb_depth;

    always_comb begin
        if (exception)
            count_next = n_keep - drain;                 // Draining entry is a kept one
        else
            count_next = count + dec_store - drain;
    end

    // Control state
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid     <= '0;
            committed <= '0;
            head      <= '0;
            tail      <= '0;
            count     <= '0;
        end else begin
            committed <= committed | done_hit;
            if (exception) begin
                valid <= keep;                           // Speculative stores gone
                tail  <= head + n_keep[lsu_pkg::sb_ptr_w-1:0];
            end else if (dec_store) begin
                valid[tail]     <= 1'b1;
                committed[tail] <= 1'b0;
                tail            <= tail + 1'b1;
            end
            if (drain) begin
                valid[head]     <= 1'b0;                 // Freed at the RAM write edge
                committed[head] <= 1'b0;
                head            <= head + 1'b1;
            end
            count <= count_next;
        end
    end

    // Entry payload, written into the free slot at tail
    always_ff @(posedge clk) begin
        if (dec_store) begin
            ent_word[tail] <= dec_word;
            ent_mask[tail] <= dec_mask;
            ent_data[tail] <= dec_wdata;
            ent_rob[tail]  <= dec_rob_idx;
        end
    end

    // Walk oldest to youngest so the youngest match overwrites each byte
    always_comb begin
        fwd_mask_c = '0;
        fwd_data_c = '0;
        fwd_idx    = head;
        for (int i = 0; i < lsu_pkg::sb_depth; i++) begin
            // Entries flushed this cycle are not forwarded
            if (valid[fwd_idx] && (!exception || keep[fwd_idx])
                && ent_word[fwd_idx] == dec_word) begin
                for (int b = 0; b < lsu_pkg::mask_w; b++) begin
                    if (ent_mask[fwd_idx][b]) begin
                        fwd_mask_c[b]        = 1'b1;
                        fwd_data_c[8*b +: 8] = ent_data[fwd_idx][8*b +: 8];
                    end
                end
            end
            fwd_idx = fwd_idx + 1'b1;
        end
    end

    // Captured at the same edge as the RAM read
    always_ff @(posedge clk) begin
        if (dec_load) begin
            fwd_mask <= fwd_mask_c;
            fwd_data <= fwd_data_c;
        end
    end

endmodule

`default_nettype wire

//--- source/lsu_request_decode.sv
`default_nettype none
`timescale 1ns/10ps

// Request register stage in front of the store buffer and the RAM
module lsu_request_decode (
    input  wire                               clk,
    input  wire                               rst_n,
    input  wire  [lsu_pkg::xlen-1:0]          addr,
    input  wire  [lsu_pkg::xlen-1:0]          wdata,
    input  wire  [2:0]                        funct3,
    input  wire  [lsu_pkg::rob_idx_w-1:0]     rob_idx,
    input  wire                               store_req,
    input  wire                               load_req,
    input  wire                               stall,
    output logic                              dec_store,
    output logic                              dec_load,
    output logic [lsu_pkg::ram_addr_w-1:0]    dec_word,
    output logic [1:0]                        dec_byte_off,
    output logic [lsu_pkg::mask_w-1:0]        dec_mask,
    output logic [lsu_pkg::xlen-1:0]          dec_wdata,
    output logic [2:0]                        dec_funct3,
    output logic [lsu_pkg::rob_idx_w-1:0]     dec_rob_idx
);

    logic                        aligned;
    logic [lsu_pkg::mask_w-1:0]  mask_c;
    logic [lsu_pkg::xlen-1:0]    lanes_c;

    // Size lives in funct3[1:0] for both loads and stores
    always_comb begin
        case (funct3[1:0])
            2'b00: begin
                aligned = 1'b1;                                  // Bytes always fit
                mask_c  = {{(lsu_pkg::mask_w-1){1'b0}}, 1'b1} << addr[1:0];
                lanes_c = {4{wdata[7:0]}};                       // Byte copied to every lane
            end
            2'b01: begin
                aligned = ~addr[0];                              // Halfword on even address
                mask_c  = {{(lsu_pkg::mask_w-2){1'b0}}, 2'b11} << addr[1:0];
                lanes_c = {2{wdata[15:0]}};
            end
            2'b10: begin
                aligned = (addr[1:0] == 2'b00);
                mask_c  = {lsu_pkg::mask_w{1'b1}};
                lanes_c = wdata;
            end
            default: begin
                // Size 3 does not exist in RV32, treated as misaligned
                aligned = 1'b0;
                mask_c  = '0;
                lanes_c = wdata;
            end
        endcase
    end

    // Strobes; a store under stall is silently lost here
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dec_store <= 1'b0;
            dec_load  <= 1'b0;
        end else begin
            dec_store <= store_req & ~stall & aligned;
            dec_load  <= load_req & aligned;
        end
    end

    // Payload follows every cycle, only meaningful with a strobe
    always_ff @(posedge clk) begin
        dec_word     <= addr[lsu_pkg::ram_addr_w+1:2];   // Word index above the byte offset
        dec_byte_off <= addr[1:0];
        dec_mask     <= mask_c;
        dec_wdata    <= lanes_c;
        dec_funct3   <= funct3;
        dec_rob_idx  <= rob_idx;
    end

endmodule

`default_nettype wire

//--- source/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

    // Datapath and address width
    localparam int xlen      = 32;
    localparam int mask_w    = xlen / 8;   // One strobe bit per byte lane

    // Width of the tag the ROB hands out per instruction
    localparam int rob_idx_w = 4;

    // Store buffer geometry
    localparam int sb_depth  = 4;
    localparam int sb_ptr_w  = 2;          // Wraps naturally at sb_depth

    // Data RAM size, in words
    localparam int ram_words  = 64;
    localparam int ram_addr_w = 6;

    // RV32 load funct3 encodings
    // Bit 2 selects zero extension, bits 1:0 the access size
    localparam logic [2:0] f3_lb  = 3'b000;
    localparam logic [2:0] f3_lh  = 3'b001;
    localparam logic [2:0] f3_lw  = 3'b010;
    localparam logic [2:0] f3_lbu = 3'b100;
    localparam logic [2:0] f3_lhu = 3'b101;

    // RV32 store funct3 encodings, same size field as loads
    localparam logic [2:0] f3_sb  = 3'b000;
    localparam logic [2:0] f3_sh  = 3'b001;
    localparam logic [2:0] f3_sw  = 3'b010;

endpackage

`default_nettype wire
